//--- Makefile
TOP   = mips_tb
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf $(BUILD) sim.log

//--- list.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/result_if.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/mem_writeback.sv
verilog/mips_core.sv
verification/mips_tb.sv

//--- verification/mips_patterns.hex
// Program length, then program words from 0x3000 upward
// Then trace record count, then records of pc, register, value
0000001f
34011234 3c02ffff 34030001 00422021 00032823 342600f0 00c13821 00e64023
00c74821 01285021 340b0100 ad6a0004 8d6c0004 018c6821 11010002 340e0055
340f0bad 10a00001 34100066 34110077 0c000c18 03e09021 34130bad 34140bad
08000c1c 34150088 34160bad 34170bad 0255c023 08000c1d 00000000
00000014
00003000 00000001 00001234
00003004 00000002 ffff0000
00003008 00000003 00000001
0000300c 00000004 fffe0000
00003010 00000005 ffffffff
00003014 00000006 000012f4
00003018 00000007 00002528
0000301c 00000008 00001234
00003020 00000009 0000381c
00003024 0000000a 00004a50
00003028 0000000b 00000100
00003030 0000000c 00004a50
00003034 0000000d 000094a0
0000303c 0000000e 00000055
00003048 00000010 00000066
0000304c 00000011 00000077
00003050 0000001f 00003058
00003054 00000012 00003058
00003064 00000015 00000088
00003070 00000018 00002fd0

//--- verification/mips_tb.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_tb;
    import mips_pkg::*;

    localparam int pat_depth  = 512;
    localparam int imem_depth = 256;
    localparam int dmem_depth = 1024;
    // Trace record count at the end of each program section
    localparam int section_end [5] = '{5, 10, 13, 16, 20};

    logic       clk = 1'b0;
    logic       reset;
    word_t      i_inst_rdata;
    word_t      i_inst_addr;
    word_t      m_data_rdata;
    word_t      m_data_addr;
    word_t      m_data_wdata;
    word_t      m_inst_addr;
    logic [3:0] m_data_byteen;
    logic       w_grf_we;
    reg_idx_t   w_grf_addr;
    word_t      w_grf_wdata;
    word_t      w_inst_addr;

    word_t patterns [0:pat_depth-1];
    word_t imem [0:imem_depth-1];
    word_t dmem [0:dmem_depth-1];

    int   prog_len = 0;
    int   trace_len = 0;
    int   trace_base = 0;
    int   next_rec = 0;
    int   section_idx = 0;
    int   section_fails = 0;
    int   pass_count = 0;
    int   fail_count = 0;
    int   cycles = 0;
    int   cycle_limit = 0;
    logic startup_done = 1'b0;
    logic run_failed = 1'b0;

    mips_core dut (
        .clk           (clk),
        .reset         (reset),
        .i_inst_rdata  (i_inst_rdata),
        .i_inst_addr   (i_inst_addr),
        .m_data_rdata  (m_data_rdata),
        .m_data_addr   (m_data_addr),
        .m_data_wdata  (m_data_wdata),
        .m_inst_addr   (m_inst_addr),
        .m_data_byteen (m_data_byteen),
        .w_grf_we      (w_grf_we),
        .w_grf_addr    (w_grf_addr),
        .w_grf_wdata   (w_grf_wdata),
        .w_inst_addr   (w_inst_addr)
    );

    always #20 clk = ~clk;

    // Reset PC has bits 9:2 clear, so the program starts at word 0
    assign i_inst_rdata = imem[i_inst_addr[9:2]];
    assign m_data_rdata = dmem[m_data_addr[11:2]];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (m_data_byteen[b]) begin
                dmem[m_data_addr[11:2]][8*b +: 8] <= m_data_wdata[8*b +: 8];
            end
        end
    end

    function automatic string section_label(input int idx);
        case (idx)
            0: return "alu results";
            1: return "dependent chain";
            2: return "store and load";
            3: return "branches";
            4: return "jumps";
            default: return "unnamed";
        endcase
    endfunction

    // All four lanes for a store word, none for anything else
    function automatic word_t expected_byteen(input word_t addr);
        word_t instr;
        if (addr < `MIPS_RESET_PC) begin
            return 32'h0;
        end
        instr = imem[addr[9:2]];
        if (instr[31:26] == `MIPS_OP_SW) begin
            return 32'h0000_000f;
        end
        return 32'h0;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name, input int fails);
        if (fails == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, fails);
        end
    endtask

    task automatic load_memories();
        $readmemh("verification/mips_patterns.hex", patterns);
        prog_len   = patterns[0];
        trace_base = prog_len + 2;
        trace_len  = patterns[prog_len + 1];
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = (i < prog_len) ? patterns[i + 1] : '0;
        end
        // Fill varies with every bit of the word address
        for (int i = 0; i < dmem_depth; i++) begin
            dmem[i] <= {16'(i) ^ 16'h5a3c, 16'(i << 2)};
        end
    endtask

    task automatic check_startup();
        check_value("w_grf_we", word_t'(w_grf_we), 32'd0);
        check_value("i_inst_addr", i_inst_addr, `MIPS_RESET_PC);
        report_test("reset", fail_count);
        startup_done = 1'b1;
    endtask

    task automatic check_store_port();
        int fails_before;
        fails_before = fail_count;
        check_value("m_data_byteen", word_t'(m_data_byteen), expected_byteen(m_inst_addr));
        section_fails += fail_count - fails_before;
    endtask

    task automatic check_record();
        int base;
        int fails_before;
        base = trace_base + 3 * next_rec;
        fails_before = fail_count;
        check_value("w_inst_addr", w_inst_addr, patterns[base]);
        check_value("w_grf_addr", word_t'(w_grf_addr), patterns[base + 1]);
        check_value("w_grf_wdata", w_grf_wdata, patterns[base + 2]);
        section_fails += fail_count - fails_before;
        next_rec++;
        if (section_idx < 5 && next_rec == section_end[section_idx]) begin
            report_test($sformatf("section %0d %s", section_idx + 1,
                                  section_label(section_idx)), section_fails);
            section_idx++;
            section_fails = 0;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            check_value("w_grf_we", word_t'(w_grf_we), 32'd0);
            check_value("m_data_byteen", word_t'(m_data_byteen), 32'd0);
        end else begin
            if (!startup_done) begin
                check_startup();
            end
            check_store_port();
            if (w_grf_we && next_rec < trace_len) begin
                check_record();
            end
        end
    end

    initial begin
        reset = 1'b1;
        load_memories();
        cycle_limit = 30 * trace_len + 50;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        while (next_rec < trace_len && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (trace_len == 0) begin
            $display("no trace records were loaded from the pattern file");
            run_failed = 1'b1;
        end else if (next_rec < trace_len) begin
            $display("timeout: only %0d of %0d trace records retired in %0d cycles",
                     next_rec, trace_len, cycles);
            run_failed = 1'b1;
        end
        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !run_failed) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module decode_unit (
    input  mips_pkg::fd_t      fd,
    result_if.sink             ex_res,
    result_if.sink             mem_res,
    result_if.sink             wb_res,
    output mips_pkg::reg_idx_t rs_idx,
    output mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::word_t    rs_val,
    input  mips_pkg::word_t    rt_val,
    output logic               stall,
    output logic               redirect,
    output mips_pkg::word_t    target,
    output mips_pkg::de_t      de
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    word_t       pc_plus_4;
    word_t       imm32;
    word_t       branch_target;
    word_t       jump_target;
    ctrl_t       ctrl;
    logic        is_branch;
    logic        is_jump;
    logic        branch_eq;
    reg_idx_t    src_idx [2];
    word_t       src_reg [2];
    word_t       src_val [2];
    logic        src_used [2];
    logic        src_wait [2];

    assign opcode    = fd.instr[31:26];
    assign funct     = fd.instr[5:0];
    assign imm16     = fd.instr[15:0];
    assign rs_idx    = fd.instr[25:21];
    assign rt_idx    = fd.instr[20:16];
    assign pc_plus_4 = fd.pc + 32'd4;

    always_comb begin
        ctrl        = '0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        src_used[0] = 1'b0;
        src_used[1] = 1'b0;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                if (funct == `MIPS_FN_ADDU || funct == `MIPS_FN_SUBU) begin
                    ctrl.alu_op = (funct == `MIPS_FN_SUBU) ? ALU_SUB : ALU_ADD;
                    ctrl.reg_we = 1'b1;
                    ctrl.dest   = fd.instr[15:11];
                    src_used[0] = 1'b1;
                    src_used[1] = 1'b1;
                end
            end
            `MIPS_OP_ORI, `MIPS_OP_LUI: begin
                ctrl.alu_op   = (opcode == `MIPS_OP_LUI) ? ALU_LUI : ALU_OR;
                ctrl.b_is_imm = 1'b1;
                ctrl.zero_ext = 1'b1;
                ctrl.reg_we   = 1'b1;
                ctrl.dest     = rt_idx;
                src_used[0]   = (opcode == `MIPS_OP_ORI);
            end
            `MIPS_OP_LW: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
                ctrl.wb_src   = WB_MEM;
                ctrl.dest     = rt_idx;
                src_used[0]   = 1'b1;
            end
            `MIPS_OP_SW: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.mem_we   = 1'b1;
                src_used[0]   = 1'b1;
                src_used[1]   = 1'b1;
            end
            `MIPS_OP_BEQ: begin
                is_branch   = 1'b1;
                src_used[0] = 1'b1;
                src_used[1] = 1'b1;
            end
            `MIPS_OP_J: is_jump = 1'b1;
            `MIPS_OP_JAL: begin
                is_jump     = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_src = WB_PC8;
                ctrl.dest   = `MIPS_RA;
            end
            default: ;
        endcase
    end

    assign imm32 = ctrl.zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    assign src_idx[0] = rs_idx;
    assign src_idx[1] = rt_idx;
    assign src_reg[0] = rs_val;
    assign src_reg[1] = rt_val;

    // Youngest producer wins
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_val[i]  = src_reg[i];
            src_wait[i] = 1'b0;
            if (ex_res.we && ex_res.dest == src_idx[i]) begin
                src_val[i]  = ex_res.data;
                src_wait[i] = !ex_res.ready;
            end else if (mem_res.we && mem_res.dest == src_idx[i]) begin
                src_val[i]  = mem_res.data;
                src_wait[i] = !mem_res.ready;
            end else if (wb_res.we && wb_res.dest == src_idx[i]) begin
                src_val[i]  = wb_res.data;
                src_wait[i] = !wb_res.ready;
            end
        end
    end

    assign stall = (src_used[0] && src_wait[0]) || (src_used[1] && src_wait[1]);

    assign branch_eq     = (src_val[0] == src_val[1]);
    assign branch_target = pc_plus_4 + {imm32[29:0], 2'b00};
    assign jump_target   = {pc_plus_4[31:28], fd.instr[25:0], 2'b00};

    // A branch only resolves on final operands
    assign redirect = is_jump || (is_branch && branch_eq && !src_wait[0] && !src_wait[1]);
    assign target   = is_jump ? jump_target : branch_target;

    assign de = '{pc: fd.pc, ctrl: ctrl, rs_val: src_val[0], rt_val: src_val[1], imm32: imm32};

    no_redirect_on_stall: assert final (!(redirect && stall));

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  mips_pkg::de_t de,
    result_if.src         ex_res,
    output mips_pkg::em_t em
);
    import mips_pkg::*;

    word_t alu_b;
    word_t alu_out;
    logic  is_link;

    assign alu_b = de.ctrl.b_is_imm ? de.imm32 : de.rt_val;

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_ADD: alu_out = de.rs_val + alu_b;
            ALU_SUB: alu_out = de.rs_val - alu_b;
            ALU_OR:  alu_out = de.rs_val | alu_b;
            ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
            default: alu_out = '0;
        endcase
    end

    assign is_link = (de.ctrl.wb_src == WB_PC8);

    // Only the link address is final in this stage
    assign ex_res.we    = de.ctrl.reg_we && (de.ctrl.dest != '0);
    assign ex_res.dest  = de.ctrl.dest;
    assign ex_res.data  = is_link ? de.pc + 32'd8 : alu_out;
    assign ex_res.ready = is_link;

    assign em = '{pc: de.pc, ctrl: de.ctrl, alu_res: alu_out, rt_val: de.rt_val};

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            redirect,
    input  mips_pkg::word_t target,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t pc_plus_4
);
    import mips_pkg::*;

    assign pc_plus_4 = pc + 32'd4;

    // Redirect arrives while the delay slot is being fetched
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            if (redirect) begin
                pc <= target;
            end else begin
                pc <= pc_plus_4;
            end
        end
    end

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    );

endmodule

//--- verilog/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::em_t      em,
    result_if.src              mem_res,
    result_if.src              wb_res,
    input  mips_pkg::word_t    m_data_rdata,
    output mips_pkg::word_t    m_data_addr,
    output mips_pkg::word_t    m_data_wdata,
    output mips_pkg::word_t    m_inst_addr,
    output logic [3:0]         m_data_byteen,
    output logic               w_grf_we,
    output mips_pkg::reg_idx_t w_grf_addr,
    output mips_pkg::word_t    w_grf_wdata,
    output mips_pkg::word_t    w_inst_addr
);
    import mips_pkg::*;

    mw_t   mw_d;
    mw_t   mw;
    word_t wb_data;
    logic  wb_we;

    // Word stores only
    assign m_data_addr   = em.alu_res;
    assign m_data_wdata  = em.rt_val;
    assign m_inst_addr   = em.pc;
    assign m_data_byteen = {4{em.ctrl.mem_we}};

    assign mem_res.we    = em.ctrl.reg_we && (em.ctrl.dest != '0);
    assign mem_res.dest  = em.ctrl.dest;
    assign mem_res.data  = (em.ctrl.wb_src == WB_PC8) ? em.pc + 32'd8 : em.alu_res;
    assign mem_res.ready = (em.ctrl.wb_src != WB_MEM);

    assign mw_d = '{pc: em.pc, ctrl: em.ctrl, alu_res: em.alu_res, mem_rdata: m_data_rdata};

    pipe_reg #(.payload_t(mw_t)) u_mw_reg (
        .clk    (clk),
        .reset  (reset),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (mw_d),
        .q      (mw)
    );

    always_comb begin
        case (mw.ctrl.wb_src)
            WB_MEM:  wb_data = mw.mem_rdata;
            WB_PC8:  wb_data = mw.pc + 32'd8;
            default: wb_data = mw.alu_res;
        endcase
    end

    assign wb_we = mw.ctrl.reg_we && (mw.ctrl.dest != '0);

    assign wb_res.we    = wb_we;
    assign wb_res.dest  = mw.ctrl.dest;
    assign wb_res.data  = wb_data;
    assign wb_res.ready = 1'b1;

    assign w_grf_we    = wb_we;
    assign w_grf_addr  = mw.ctrl.dest;
    assign w_grf_wdata = wb_data;
    assign w_inst_addr = mw.pc;

endmodule

//--- verilog/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::word_t    i_inst_rdata,
    output mips_pkg::word_t    i_inst_addr,
    input  mips_pkg::word_t    m_data_rdata,
    output mips_pkg::word_t    m_data_addr,
    output mips_pkg::word_t    m_data_wdata,
    output mips_pkg::word_t    m_inst_addr,
    output logic [3:0]         m_data_byteen,
    output logic               w_grf_we,
    output mips_pkg::reg_idx_t w_grf_addr,
    output mips_pkg::word_t    w_grf_wdata,
    output mips_pkg::word_t    w_inst_addr
);
    import mips_pkg::*;

    logic     stall;
    logic     redirect;
    word_t    target;
    word_t    pc;
    fd_t      fd_d;
    fd_t      fd_q;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_val;
    word_t    rt_val;
    de_t      de_d;
    de_t      de_q;
    em_t      em_d;
    em_t      em_q;

    result_if ex_res ();
    result_if mem_res ();
    result_if wb_res ();

    fetch_unit u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .pc        (pc),
        .pc_plus_4 ()
    );

    assign i_inst_addr = pc;
    assign fd_d = '{instr: i_inst_rdata, pc: pc};

    pipe_reg #(.payload_t(fd_t)) u_fd_reg (
        .clk (clk), .reset (reset), .hold (stall), .bubble (1'b0), .d (fd_d), .q (fd_q)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wr     (wb_res)
    );

    decode_unit u_decode (
        .fd       (fd_q),
        .ex_res   (ex_res),
        .mem_res  (mem_res),
        .wb_res   (wb_res),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .de       (de_d)
    );

    // Stalled instruction stays in F/D while execute gets a bubble
    pipe_reg #(.payload_t(de_t)) u_de_reg (
        .clk (clk), .reset (reset), .hold (1'b0), .bubble (stall), .d (de_d), .q (de_q)
    );

    execute_unit u_execute (
        .de     (de_q),
        .ex_res (ex_res),
        .em     (em_d)
    );

    pipe_reg #(.payload_t(em_t)) u_em_reg (
        .clk (clk), .reset (reset), .hold (1'b0), .bubble (1'b0), .d (em_d), .q (em_q)
    );

    mem_writeback u_mem_wb (
        .clk           (clk),
        .reset         (reset),
        .em            (em_q),
        .mem_res       (mem_res),
        .wb_res        (wb_res),
        .m_data_rdata  (m_data_rdata),
        .m_data_addr   (m_data_addr),
        .m_data_wdata  (m_data_wdata),
        .m_inst_addr   (m_inst_addr),
        .m_data_byteen (m_data_byteen),
        .w_grf_we      (w_grf_we),
        .w_grf_addr    (w_grf_addr),
        .w_grf_wdata   (w_grf_wdata),
        .w_inst_addr   (w_inst_addr)
    );

endmodule

//--- verilog/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_WORD_W    32
`define MIPS_REG_AW    5
`define MIPS_RESET_PC  32'h0000_3000
`define MIPS_RA        5'd31

// Primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

// Function field under SPECIAL
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23

`endif

//--- verilog/mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_OR  = 2'd2,
        ALU_LUI = 2'd3
    } alu_op_t;

    // Value written back to the register file
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC8 = 2'd2
    } wb_src_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     b_is_imm;
        logic     zero_ext;
        logic     mem_we;
        logic     reg_we;
        wb_src_t  wb_src;
        reg_idx_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fd_t;

    // Operands here are already final
    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t rs_val;
        word_t rt_val;
        word_t imm32;
    } de_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t alu_res;
        word_t rt_val;
    } em_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t alu_res;
        word_t mem_rdata;
    } mw_t;

endpackage

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // A bubble is the all-zero payload, which carries no writes
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

    hold_bubble_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(hold && bubble)
    );

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_val,
    output mips_pkg::word_t    rt_val,
    result_if.sink             wr
);
    import mips_pkg::*;

    // Register 0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we) begin
            regs[wr.dest] <= wr.data;
        end
    end

    // Decode forwards the writeback value since reads see the old one
    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];

    // The writeback stage filters out writes to register 0
    no_write_to_zero: assert property (
        @(posedge clk) disable iff (reset) wr.we |-> (wr.dest != '0)
    );

endmodule

//--- verilog/result_if.sv
`timescale 1ns/1ps

// One stage's pending register write, as seen from decode
interface result_if;
    import mips_pkg::*;

    logic     we;
    reg_idx_t dest;
    word_t    data;
    logic     ready;

    modport src (
        output we, dest, data, ready
    );

    modport sink (
        input we, dest, data, ready
    );

endinterface
